// File: verilog/dispatch_pkg.sv
`default_nettype none

package dispatch_pkg;

   // Datapath and register file sizes.
   localparam int DATA_W     = 32;
   localparam int REG_ADDR_W = 5;
   localparam int NUM_REGS   = 32;
   localparam int IMM_W      = 16;

   // Every tag in circulation fits in TAG_W bits.
   localparam int TAG_W    = 6;
   localparam int NUM_TAGS = 64;

   typedef logic [TAG_W-1:0]      tag_t;
   typedef logic [DATA_W-1:0]     data_t;
   typedef logic [REG_ADDR_W-1:0] reg_addr_t;

   // Execution queue selected by the decoder.
   typedef enum logic [1:0] {
      Q_INT  = 2'd0,
      Q_LS   = 2'd1,
      Q_MULT = 2'd2,
      Q_DIV  = 2'd3
   } queue_sel_t;

   // MIPS primary opcodes handled by the stage.
   localparam logic [5:0] OP_RTYPE = 6'h00;
   localparam logic [5:0] OP_J     = 6'h02;
   localparam logic [5:0] OP_BEQ   = 6'h04;
   localparam logic [5:0] OP_BNE   = 6'h05;
   localparam logic [5:0] OP_LW    = 6'h23;
   localparam logic [5:0] OP_SW    = 6'h2b;

   // R-type function codes that leave the integer queue.
   localparam logic [5:0] FN_MULT  = 6'h18;
   localparam logic [5:0] FN_MULTU = 6'h19;
   localparam logic [5:0] FN_DIV   = 6'h1a;
   localparam logic [5:0] FN_DIVU  = 6'h1b;

   // Load/store queue opcode.
   localparam logic LS_FUNC_LW = 1'b0;
   localparam logic LS_FUNC_SW = 1'b1;

endpackage

`default_nettype wire

// File: verilog/cdb_if.sv
`timescale 1ns/1ps
`default_nettype none

// Common data bus as seen by the dispatch stage.
interface cdb_if import dispatch_pkg::*; ();

   tag_t  tag;
   logic  valid;
   data_t data;
   logic  branch;
   logic  taken;

   modport listener (input tag, input valid, input data, input branch, input taken);

   // Result writeback only needs the tag and the data.
   modport writeback (input tag, input valid, input data);

endinterface

`default_nettype wire

// File: verilog/dispatch_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module dispatch_ctrl import dispatch_pkg::*; (
   input  logic           clk,
   input  logic           rst,
   input  data_t          inst,
   input  logic           ifq_empty,
   input  logic           int_ready,
   input  logic           ls_ready,
   input  logic           mult_ready,
   input  logic           div_ready,
   input  logic           tag_empty,
   cdb_if.listener        cdb,
   output logic           ifq_ren,
   output logic           int_en,
   output logic           ls_en,
   output logic           mult_en,
   output logic           div_en,
   output logic [5:0]     int_opcode,
   output logic           ls_opcode,
   output logic           claim,
   output reg_addr_t      dest_addr,
   output logic           load_sel,
   output logic           store_sel,
   output logic           branch_capture,
   output logic           jump_redirect,
   output logic           branch_redirect
);

   typedef enum logic {S_DISPATCH, S_BRANCH_STALL} state_t;

   state_t     state;
   state_t     next_state;
   queue_sel_t sel;
   logic       can_issue;
   logic       need_tag;
   logic       is_branch;
   logic       is_jump;
   logic       sel_ready;
   logic       slot_open;
   logic       do_dispatch;

   always_comb begin
      sel        = Q_INT;
      can_issue  = 1'b0;
      need_tag   = 1'b0;
      is_branch  = 1'b0;
      is_jump    = 1'b0;
      load_sel   = 1'b0;
      store_sel  = 1'b0;
      int_opcode = 6'h00;
      ls_opcode  = LS_FUNC_LW;
      case (inst[31:26])
         OP_RTYPE: begin
            can_issue = 1'b1;
            need_tag  = 1'b1;
            if (inst[5:0] == FN_MULT || inst[5:0] == FN_MULTU) begin
               sel = Q_MULT;
            end else if (inst[5:0] == FN_DIV || inst[5:0] == FN_DIVU) begin
               sel = Q_DIV;
            end else begin
               int_opcode = inst[5:0];
            end
         end
         OP_BEQ, OP_BNE: begin
            // The integer queue resolves the branch from the opcode.
            can_issue  = 1'b1;
            is_branch  = 1'b1;
            int_opcode = inst[31:26];
         end
         OP_J: is_jump = 1'b1;
         OP_LW: begin
            sel       = Q_LS;
            can_issue = 1'b1;
            need_tag  = 1'b1;
            load_sel  = 1'b1;
            ls_opcode = LS_FUNC_LW;
         end
         OP_SW: begin
            sel       = Q_LS;
            can_issue = 1'b1;
            store_sel = 1'b1;
            ls_opcode = LS_FUNC_SW;
         end
         default: can_issue = 1'b0;
      endcase
   end

   always_comb begin
      case (sel)
         Q_INT:   sel_ready = int_ready;
         Q_LS:    sel_ready = ls_ready;
         Q_MULT:  sel_ready = mult_ready;
         default: sel_ready = div_ready;
      endcase
   end

   // A stall ends in the cycle that the CDB resolves the branch as not taken.
   assign slot_open   = (state == S_DISPATCH) ||
                        (cdb.branch && !cdb.taken);
   assign do_dispatch = !ifq_empty && can_issue && sel_ready &&
                        (!need_tag || !tag_empty) && slot_open;

   assign ifq_ren        = do_dispatch;
   assign int_en         = do_dispatch && (sel == Q_INT);
   assign ls_en          = do_dispatch && (sel == Q_LS);
   assign mult_en        = do_dispatch && (sel == Q_MULT);
   assign div_en         = do_dispatch && (sel == Q_DIV);
   assign claim          = do_dispatch && need_tag;
   assign branch_capture = do_dispatch && is_branch;
   assign dest_addr      = load_sel ? inst[20:16] : inst[15:11];

   // The fetch queue flushes itself on a redirect, so a jump never reads it.
   assign jump_redirect   = (state == S_DISPATCH) && !ifq_empty && is_jump;
   assign branch_redirect = (state == S_BRANCH_STALL) && cdb.branch && cdb.taken;

   always_comb begin
      next_state = state;
      if (branch_capture) begin
         next_state = S_BRANCH_STALL;
      end else if (state == S_BRANCH_STALL && cdb.branch) begin
         next_state = S_DISPATCH;
      end
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         state <= S_DISPATCH;
      end else begin
         state <= next_state;
      end
   end

   // Only one branch is in flight, so it resolves while the stage waits for it.
   a_resolve_in_stall: assert property (@(posedge clk) disable iff (rst)
      cdb.branch |-> state == S_BRANCH_STALL)
      else $error("Branch resolved on the CDB outside a branch stall");

   a_taken_is_branch: assert property (@(posedge clk) disable iff (rst)
      cdb.taken |-> cdb.branch)
      else $error("CDB taken flag raised without a branch");

endmodule

`default_nettype wire

// File: verilog/tag_fifo.sv
`timescale 1ns/1ps
`default_nettype none

module tag_fifo import dispatch_pkg::*; (
   input  logic      clk,
   input  logic      rst,
   input  logic      pop,
   cdb_if.writeback  cdb,
   output tag_t      head_tag,
   output logic      empty
);

   // NUM_TAGS is a power of two, so the pointers wrap on their own.
   tag_t             mem [NUM_TAGS];
   logic [TAG_W-1:0] rd_ptr;
   logic [TAG_W-1:0] wr_ptr;
   logic [TAG_W:0]   count;

   assign head_tag = mem[rd_ptr];
   assign empty    = (count == '0);

   always_ff @(posedge clk) begin
      if (rst) begin
         for (int i = 0; i < NUM_TAGS; i++) begin
            mem[i] <= tag_t'(i);
         end
         rd_ptr <= '0;
         wr_ptr <= '0;
         count  <= (TAG_W+1)'(NUM_TAGS);
      end else begin
         if (cdb.valid) begin
            mem[wr_ptr] <= cdb.tag;
            wr_ptr      <= wr_ptr + 1'b1;
         end
         if (pop) begin
            rd_ptr <= rd_ptr + 1'b1;
         end
         count <= count + (TAG_W+1)'(cdb.valid) - (TAG_W+1)'(pop);
      end
   end

   a_no_pop_empty: assert property (@(posedge clk) disable iff (rst)
      pop |-> !empty)
      else $error("Tag popped from an empty free list");

endmodule

`default_nettype wire

// File: verilog/reg_status_table.sv
`timescale 1ns/1ps
`default_nettype none

module reg_status_table import dispatch_pkg::*; (
   input  logic                clk,
   input  logic                rst,
   input  reg_addr_t           rs_addr,
   input  reg_addr_t           rt_addr,
   input  reg_addr_t           dest_addr,
   input  logic                claim,
   input  tag_t                new_tag,
   cdb_if.writeback            cdb,
   output tag_t                rs_tag,
   output tag_t                rt_tag,
   output logic                rs_busy,
   output logic                rt_busy,
   output logic [NUM_REGS-1:0] write_onehot
);

   logic [NUM_REGS-1:0] busy;
   tag_t                producer [NUM_REGS];

   assign rs_tag  = producer[rs_addr];
   assign rt_tag  = producer[rt_addr];
   assign rs_busy = busy[rs_addr];
   assign rt_busy = busy[rt_addr];

   // A register takes the broadcast only while it waits on that tag.
   always_comb begin
      for (int i = 0; i < NUM_REGS; i++) begin
         write_onehot[i] = busy[i] && cdb.valid && (producer[i] == cdb.tag);
      end
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         busy <= '0;
      end else begin
         busy <= busy & ~write_onehot;
         // A new claim on the same register overrides the clear.
         if (claim) begin
            busy[dest_addr] <= 1'b1;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (claim) begin
         producer[dest_addr] <= new_tag;
      end
   end

endmodule

`default_nettype wire

// File: verilog/reg_file.sv
`timescale 1ns/1ps
`default_nettype none

module reg_file import dispatch_pkg::*; (
   input  logic                clk,
   input  logic                rst,
   input  logic [NUM_REGS-1:0] write_onehot,
   cdb_if.writeback            cdb,
   input  reg_addr_t           rs_addr,
   input  reg_addr_t           rt_addr,
   input  reg_addr_t           debug_addr,
   output data_t               rs_data,
   output data_t               rt_data,
   output data_t               debug_data
);

   data_t regs [NUM_REGS];

   // Several registers may wait on the same tag and take one broadcast.
   always_ff @(posedge clk) begin
      for (int i = 0; i < NUM_REGS; i++) begin
         if (rst) begin
            regs[i] <= '0;
         end else if (write_onehot[i]) begin
            regs[i] <= cdb.data;
         end
      end
   end

   assign rs_data    = regs[rs_addr];
   assign rt_data    = regs[rt_addr];
   assign debug_data = regs[debug_addr];

endmodule

`default_nettype wire

// File: verilog/operand_select.sv
`timescale 1ns/1ps
`default_nettype none

module operand_select import dispatch_pkg::*; (
   input  logic             clk,
   input  logic             rst,
   input  data_t            inst,
   input  data_t            pc_plus4,
   input  tag_t             rs_tag,
   input  tag_t             rt_tag,
   input  logic             rs_busy,
   input  logic             rt_busy,
   input  data_t            rs_file_data,
   input  data_t            rt_file_data,
   input  tag_t             new_tag,
   input  logic             load_sel,
   input  logic             store_sel,
   input  logic             branch_capture,
   input  logic             jump_redirect,
   input  logic             branch_redirect,
   cdb_if.listener          cdb,
   output logic [IMM_W-1:0] q_imm,
   output tag_t             q_rd_tag,
   output tag_t             q_rs_tag,
   output tag_t             q_rt_tag,
   output data_t            q_rs_data,
   output data_t            q_rt_data,
   output logic             q_rs_valid,
   output logic             q_rt_valid,
   output data_t            ifq_branch_addr,
   output logic             ifq_branch_valid
);

   logic  rs_hit;
   logic  rt_hit;
   data_t branch_target;
   data_t jump_target;
   data_t target_q;

   // Bypass a result that is broadcast in the same cycle as the read.
   assign rs_hit = rs_busy && cdb.valid && (cdb.tag == rs_tag);
   assign rt_hit = rt_busy && cdb.valid && (cdb.tag == rt_tag);

   assign q_imm      = inst[IMM_W-1:0];
   assign q_rd_tag   = new_tag;
   assign q_rs_tag   = rs_tag;
   assign q_rs_data  = rs_hit ? cdb.data : rs_file_data;
   assign q_rs_valid = !rs_busy || rs_hit;

   // A load writes rt, so rt carries the load's own tag.
   assign q_rt_tag   = load_sel ? new_tag : rt_tag;
   assign q_rt_data  = rt_hit ? cdb.data : rt_file_data;
   assign q_rt_valid = store_sel || !rt_busy || rt_hit;

   assign branch_target = pc_plus4 +
      {{(DATA_W-IMM_W-2){inst[IMM_W-1]}}, inst[IMM_W-1:0], 2'b00};
   assign jump_target   = {pc_plus4[31:28], inst[25:0], 2'b00};

   // Held until the CDB resolves the branch.
   always_ff @(posedge clk) begin
      if (rst) begin
         target_q <= '0;
      end else if (branch_capture) begin
         target_q <= branch_target;
      end
   end

   assign ifq_branch_valid = jump_redirect || branch_redirect;
   assign ifq_branch_addr  = jump_redirect   ? jump_target :
                             branch_redirect ? target_q    : '0;

endmodule

`default_nettype wire

// File: verilog/dispatch.sv
`timescale 1ns/1ps
`default_nettype none

module dispatch import dispatch_pkg::*; (
   input  logic             clk,
   input  logic             rst,
   input  data_t            ifq_pc_plus4,
   input  data_t            ifq_inst,
   input  logic             ifq_empty,
   output logic             ifq_ren,
   output data_t            ifq_branch_addr,
   output logic             ifq_branch_valid,
   input  tag_t             cdb_tag,
   input  logic             cdb_valid,
   input  data_t            cdb_data,
   input  logic             cdb_branch,
   input  logic             cdb_branch_taken,
   output logic [IMM_W-1:0] q_imm,
   output tag_t             q_rd_tag,
   output tag_t             q_rs_tag,
   output tag_t             q_rt_tag,
   output data_t            q_rs_data,
   output data_t            q_rt_data,
   output logic             q_rs_valid,
   output logic             q_rt_valid,
   output logic             ls_opcode,
   output logic             ls_en,
   input  logic             ls_ready,
   output logic [5:0]       int_opcode,
   output logic             int_en,
   input  logic             int_ready,
   output logic             mult_en,
   input  logic             mult_ready,
   output logic             div_en,
   input  logic             div_ready,
   input  reg_addr_t        debug_addr,
   output data_t            debug_data
);

   tag_t                head_tag;
   logic                tag_empty;
   logic                claim;
   reg_addr_t           dest_addr;
   logic                load_sel;
   logic                store_sel;
   logic                branch_capture;
   logic                jump_redirect;
   logic                branch_redirect;
   tag_t                rs_tag;
   tag_t                rt_tag;
   logic                rs_busy;
   logic                rt_busy;
   logic [NUM_REGS-1:0] write_onehot;
   data_t               rs_data;
   data_t               rt_data;

   cdb_if u_cdb ();

   assign u_cdb.tag    = cdb_tag;
   assign u_cdb.valid  = cdb_valid;
   assign u_cdb.data   = cdb_data;
   assign u_cdb.branch = cdb_branch;
   assign u_cdb.taken  = cdb_branch_taken;

   dispatch_ctrl u_ctrl (
      .clk(clk), .rst(rst), .inst(ifq_inst), .ifq_empty(ifq_empty),
      .int_ready(int_ready), .ls_ready(ls_ready), .mult_ready(mult_ready),
      .div_ready(div_ready), .tag_empty(tag_empty), .cdb(u_cdb.listener),
      .ifq_ren(ifq_ren), .int_en(int_en), .ls_en(ls_en), .mult_en(mult_en),
      .div_en(div_en), .int_opcode(int_opcode), .ls_opcode(ls_opcode),
      .claim(claim), .dest_addr(dest_addr), .load_sel(load_sel),
      .store_sel(store_sel), .branch_capture(branch_capture),
      .jump_redirect(jump_redirect), .branch_redirect(branch_redirect)
   );

   tag_fifo u_tag_fifo (
      .clk(clk), .rst(rst), .pop(claim), .cdb(u_cdb.writeback),
      .head_tag(head_tag), .empty(tag_empty)
   );

   reg_status_table u_status (
      .clk(clk), .rst(rst), .rs_addr(ifq_inst[25:21]), .rt_addr(ifq_inst[20:16]),
      .dest_addr(dest_addr), .claim(claim), .new_tag(head_tag),
      .cdb(u_cdb.writeback), .rs_tag(rs_tag), .rt_tag(rt_tag),
      .rs_busy(rs_busy), .rt_busy(rt_busy), .write_onehot(write_onehot)
   );

   reg_file u_reg_file (
      .clk(clk), .rst(rst), .write_onehot(write_onehot), .cdb(u_cdb.writeback),
      .rs_addr(ifq_inst[25:21]), .rt_addr(ifq_inst[20:16]),
      .debug_addr(debug_addr), .rs_data(rs_data), .rt_data(rt_data),
      .debug_data(debug_data)
   );

   operand_select u_operands (
      .clk(clk), .rst(rst), .inst(ifq_inst), .pc_plus4(ifq_pc_plus4),
      .rs_tag(rs_tag), .rt_tag(rt_tag), .rs_busy(rs_busy), .rt_busy(rt_busy),
      .rs_file_data(rs_data), .rt_file_data(rt_data), .new_tag(head_tag),
      .load_sel(load_sel), .store_sel(store_sel),
      .branch_capture(branch_capture), .jump_redirect(jump_redirect),
      .branch_redirect(branch_redirect), .cdb(u_cdb.listener),
      .q_imm(q_imm), .q_rd_tag(q_rd_tag), .q_rs_tag(q_rs_tag),
      .q_rt_tag(q_rt_tag), .q_rs_data(q_rs_data), .q_rt_data(q_rt_data),
      .q_rs_valid(q_rs_valid), .q_rt_valid(q_rt_valid),
      .ifq_branch_addr(ifq_branch_addr), .ifq_branch_valid(ifq_branch_valid)
   );

endmodule

`default_nettype wire

// File: dv/tb_dispatch.sv
`timescale 1ns/1ps
`default_nettype none

module tb_dispatch import dispatch_pkg::*; ();

   localparam int QUIET_TIMEOUT = 20;
   localparam int MAX_CYCLES    = 500;

   // Bits of the check mask column in the stimulus file.
   localparam logic [31:0] CHK_OPCODE = 32'h01;
   localparam logic [31:0] CHK_RS     = 32'h02;
   localparam logic [31:0] CHK_RT     = 32'h04;
   localparam logic [31:0] CHK_RT_TAG = 32'h08;
   localparam logic [31:0] CHK_TARGET = 32'h10;
   localparam logic [31:0] CHK_DEBUG  = 32'h20;
   localparam logic [31:0] CHK_RD_TAG = 32'h40;

   logic             clk;
   logic             rst;
   data_t            ifq_pc_plus4;
   data_t            ifq_inst;
   logic             ifq_empty;
   logic             ifq_ren;
   data_t            ifq_branch_addr;
   logic             ifq_branch_valid;
   tag_t             cdb_tag;
   logic             cdb_valid;
   data_t            cdb_data;
   logic             cdb_branch;
   logic             cdb_branch_taken;
   logic [IMM_W-1:0] q_imm;
   tag_t             q_rd_tag;
   tag_t             q_rs_tag;
   tag_t             q_rt_tag;
   data_t            q_rs_data;
   data_t            q_rt_data;
   logic             q_rs_valid;
   logic             q_rt_valid;
   logic             ls_opcode;
   logic             ls_en;
   logic             ls_ready;
   logic [5:0]       int_opcode;
   logic             int_en;
   logic             int_ready;
   logic             mult_en;
   logic             mult_ready;
   logic             div_en;
   logic             div_ready;
   reg_addr_t        debug_addr;
   data_t            debug_data;

   int          errors;
   int          checks;
   int          cycles;
   logic        aborted;

   // One line of the stimulus file: inputs first, then expected outputs.
   int          row_rep;
   logic [31:0] row_empty, row_inst, row_pc, row_cdb, row_ctag, row_cdata;
   logic [31:0] row_rdy, row_dbg, row_mask, exp_en, exp_ctl, exp_baddr;
   logic [31:0] exp_iop, exp_lop, exp_rdt, exp_rst, exp_rsv, exp_rsd;
   logic [31:0] exp_rtt, exp_rtv, exp_rtd, exp_dbgd;

   dispatch u_dispatch (
      .clk(clk), .rst(rst), .ifq_pc_plus4(ifq_pc_plus4), .ifq_inst(ifq_inst),
      .ifq_empty(ifq_empty), .ifq_ren(ifq_ren), .ifq_branch_addr(ifq_branch_addr),
      .ifq_branch_valid(ifq_branch_valid), .cdb_tag(cdb_tag), .cdb_valid(cdb_valid),
      .cdb_data(cdb_data), .cdb_branch(cdb_branch), .cdb_branch_taken(cdb_branch_taken),
      .q_imm(q_imm), .q_rd_tag(q_rd_tag), .q_rs_tag(q_rs_tag), .q_rt_tag(q_rt_tag),
      .q_rs_data(q_rs_data), .q_rt_data(q_rt_data), .q_rs_valid(q_rs_valid),
      .q_rt_valid(q_rt_valid), .ls_opcode(ls_opcode), .ls_en(ls_en),
      .ls_ready(ls_ready), .int_opcode(int_opcode), .int_en(int_en),
      .int_ready(int_ready), .mult_en(mult_en), .mult_ready(mult_ready),
      .div_en(div_en), .div_ready(div_ready), .debug_addr(debug_addr),
      .debug_data(debug_data)
   );

   always #5 clk = ~clk;

   task automatic check_value(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
      checks++;
      if (actual !== expected) begin
         errors++;
         $display("[FAIL] %0t %s expected %h actual %h", $time, name, expected, actual);
      end
   endtask

   task automatic drive_row();
      ifq_empty        <= row_empty[0];
      ifq_inst         <= row_inst;
      ifq_pc_plus4     <= row_pc;
      cdb_valid        <= row_cdb[2];
      cdb_branch       <= row_cdb[1];
      cdb_branch_taken <= row_cdb[0];
      cdb_tag          <= row_ctag[TAG_W-1:0];
      cdb_data         <= row_cdata;
      int_ready        <= row_rdy[3];
      ls_ready         <= row_rdy[2];
      mult_ready       <= row_rdy[1];
      div_ready        <= row_rdy[0];
      debug_addr       <= row_dbg[REG_ADDR_W-1:0];
   endtask

   // Within a repeated row the free list hands out one tag per dispatch in order.
   task automatic compare_outputs(input int step);
      logic [31:0] rd_exp;
      rd_exp = (exp_rdt + 32'(step)) % 32'(NUM_TAGS);
      check_value("int_en", 32'(exp_en[3]), 32'(int_en));
      check_value("ls_en", 32'(exp_en[2]), 32'(ls_en));
      check_value("mult_en", 32'(exp_en[1]), 32'(mult_en));
      check_value("div_en", 32'(exp_en[0]), 32'(div_en));
      check_value("ifq_ren", 32'(exp_ctl[1]), 32'(ifq_ren));
      check_value("ifq_branch_valid", 32'(exp_ctl[0]), 32'(ifq_branch_valid));
      if ((row_mask & CHK_OPCODE) != 0) begin
         check_value("int_opcode", exp_iop, 32'(int_opcode));
         check_value("ls_opcode", exp_lop, 32'(ls_opcode));
      end
      // A dispatched instruction hands its raw 16-bit immediate field to the queue.
      if (exp_ctl[1]) begin
         check_value("q_imm", 32'(row_inst[15:0]), 32'(q_imm));
      end
      if ((row_mask & CHK_RD_TAG) != 0) begin
         check_value("q_rd_tag", rd_exp, 32'(q_rd_tag));
      end
      // A ready operand carries data and a waiting one carries its producer's tag.
      if ((row_mask & CHK_RS) != 0) begin
         check_value("q_rs_valid", 32'(exp_rsv[0]), 32'(q_rs_valid));
         if (exp_rsv[0]) begin
            check_value("q_rs_data", exp_rsd, q_rs_data);
         end else begin
            check_value("q_rs_tag", exp_rst, 32'(q_rs_tag));
         end
      end
      if ((row_mask & CHK_RT) != 0) begin
         check_value("q_rt_valid", 32'(exp_rtv[0]), 32'(q_rt_valid));
         if (exp_rtv[0]) begin
            check_value("q_rt_data", exp_rtd, q_rt_data);
         end else begin
            check_value("q_rt_tag", exp_rtt, 32'(q_rt_tag));
         end
      end
      if ((row_mask & CHK_RT_TAG) != 0) begin
         check_value("q_rt_tag", exp_rtt, 32'(q_rt_tag));
      end
      if ((row_mask & CHK_TARGET) != 0) begin
         check_value("ifq_branch_addr", exp_baddr, ifq_branch_addr);
      end
      if ((row_mask & CHK_DEBUG) != 0) begin
         check_value("debug_data", exp_dbgd, debug_data);
      end
   endtask

   task automatic run_row();
      for (int i = 0; i < row_rep && !aborted; i++) begin
         @(posedge clk);
         drive_row();
         @(negedge clk);
         compare_outputs(i);
         cycles++;
         if (cycles >= MAX_CYCLES) begin
            $display("Timeout: the stimulus ran past %0d cycles", MAX_CYCLES);
            errors++;
            aborted = 1'b1;
         end
      end
   endtask

   task automatic wait_quiet();
      int waited;
      waited = 0;
      @(negedge clk);
      while ((ifq_ren || ifq_branch_valid || int_en || ls_en || mult_en || div_en) &&
             waited < QUIET_TIMEOUT) begin
         @(negedge clk);
         waited++;
      end
      if (ifq_ren || ifq_branch_valid || int_en || ls_en || mult_en || div_en) begin
         $display("Timeout: enables still high %0d cycles after reset", QUIET_TIMEOUT);
         errors++;
         aborted = 1'b1;
      end
   endtask

   initial begin
      int               fd;
      int               n;
      logic [8*256-1:0] line;
      clk              = 1'b0;
      rst              = 1'b1;
      ifq_pc_plus4     = '0;
      ifq_inst         = '0;
      ifq_empty        = 1'b1;
      cdb_tag          = '0;
      cdb_valid        = 1'b0;
      cdb_data         = '0;
      cdb_branch       = 1'b0;
      cdb_branch_taken = 1'b0;
      ls_ready         = 1'b0;
      int_ready        = 1'b0;
      mult_ready       = 1'b0;
      div_ready        = 1'b0;
      debug_addr       = '0;
      errors           = 0;
      checks           = 0;
      cycles           = 0;
      aborted          = 1'b0;
      repeat (10) @(posedge clk);
      rst <= 1'b0;
      wait_quiet();
      fd = $fopen("dv/dispatch_input.txt", "r");
      if (fd == 0) begin
         $display("Could not open the stimulus file dv/dispatch_input.txt");
         errors++;
      end else begin
         while (!$feof(fd) && !aborted) begin
            line = '0;
            if ($fgets(line, fd) > 0) begin
               // Comment lines start with a hash and match no field.
               n = $sscanf(line,
                  "%d %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                  row_rep, row_empty, row_inst, row_pc, row_cdb, row_ctag, row_cdata,
                  row_rdy, row_dbg, row_mask, exp_en, exp_ctl, exp_baddr, exp_iop,
                  exp_lop, exp_rdt, exp_rst, exp_rsv, exp_rsd, exp_rtt, exp_rtv,
                  exp_rtd, exp_dbgd);
               if (n == 23) begin
                  run_row();
               end else if (n > 0) begin
                  $display("Malformed line in the stimulus file with %0d fields", n);
                  errors++;
               end
            end
         end
         $fclose(fd);
      end
      $display("Checks: %0d, errors: %0d", checks, errors);
      if (errors == 0) begin
         $display("Result: PASSED");
      end else begin
         $display("Result: FAILED");
      end
      $finish;
   end

endmodule

`default_nettype wire

// File: dispatch.f
verilog/dispatch_pkg.sv
verilog/cdb_if.sv
verilog/dispatch_ctrl.sv
verilog/tag_fifo.sv
verilog/reg_status_table.sv
verilog/reg_file.sv
verilog/operand_select.sv
verilog/dispatch.sv
dv/tb_dispatch.sv

// File: Makefile
LOG = sim.log

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -j 0 --top-module tb_dispatch -f dispatch.f -o tb_dispatch

run: compile
	./obj_dir/tb_dispatch | tee $(LOG)
	grep -q "Result: PASSED" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// File: dv/dispatch_input.txt
# rep empty inst pc cdb ctag cdata rdy dbg mask en ctl baddr iop lop rdt rst rsv rsd rtt rtv rtd dbgd
# rep is decimal, the rest hex; cdb = {valid,branch,taken}; rdy, en = {int,ls,mult,div}; ctl = {ren,bv}
# Idle after reset
1  1 00000000 0 0 0 0 f 0  20 0 0 0 0 0 0 0 0 0 0 0 0 0
# R-type run, then MULT and DIV
1  0 00221820 0 0 0 0 f 0  47 8 2 0 20 0 0 0 1 0 0 1 0 0
1  0 00612022 0 0 0 0 f 0  47 8 2 0 22 0 1 0 0 0 0 1 0 0
1  0 00a60018 0 0 0 0 f 0  40 2 2 0 0 0 2 0 0 0 0 0 0 0
1  0 00e8001a 0 0 0 0 f 0  40 1 2 0 0 0 3 0 0 0 0 0 0 0
# Dependencies, CDB bypass, tag reuse and an empty free list
1  0 00834825 0 4 1 1234 f 0  47 8 2 0 25 0 4 1 1 1234 0 0 0 0
1  0 00835024 0 0 0 0 f 4  67 8 2 0 24 0 5 0 1 1234 0 0 0 1234
58 0 00225820 0 0 0 0 f 0  41 8 2 0 20 0 6 0 0 0 0 0 0 0
1  0 00225820 0 0 0 0 f 0  41 8 2 0 20 0 1 0 0 0 0 0 0 0
1  0 00226020 0 0 0 0 f 0  00 0 0 0 0 0 0 0 0 0 0 0 0 0
1  0 00226020 0 4 0 77 f 0  00 0 0 0 0 0 0 0 0 0 0 0 0 0
1  0 00226020 0 0 0 0 f 3  61 8 2 0 20 0 0 0 0 0 0 0 0 77
# Store without a tag, then a load
1  0 ac830008 0 4 4 99 f 0  07 4 2 0 0 1 0 0 1 1234 0 1 77 0
1  0 8d2d0004 0 4 6 0 f 9  6b 4 2 0 0 0 4 0 1 99 4 0 0 99
# Taken branch
1  0 10220010 100 4 5 55 f 0  07 8 2 0 04 0 0 0 1 0 0 1 0 0
1  0 00227020 0 0 0 0 f 0  00 0 0 0 0 0 0 0 0 0 0 0 0 0
1  0 00227020 0 3 0 0 f 0  10 0 1 140 0 0 0 0 0 0 0 0 0 0
1  0 00227020 0 0 0 0 f 0  41 8 2 0 20 0 6 0 0 0 0 0 0 0
# Not-taken branch and jump
1  0 1422fffc 200 0 0 0 f 0  01 8 2 0 05 0 0 0 0 0 0 0 0 0
1  0 00227820 0 0 0 0 f 0  00 0 0 0 0 0 0 0 0 0 0 0 0 0
1  0 00227820 0 2 0 0 f 0  41 8 2 0 20 0 5 0 0 0 0 0 0 0
1  0 08000040 30000010 4 7 0 f 0  10 0 1 30000100 0 0 0 0 0 0 0 0 0 0
# Back-pressure from a low ready and an empty fetch queue
1  0 00228020 0 0 0 0 7 0  40 0 0 0 0 0 7 0 0 0 0 0 0 0
1  1 00228020 0 0 0 0 f 0  40 0 0 0 0 0 7 0 0 0 0 0 0 0
1  0 00228020 0 0 0 0 f 0  41 8 2 0 20 0 7 0 0 0 0 0 0 0
1  1 00000000 0 0 0 0 f a  20 0 0 0 0 0 0 0 0 0 0 0 0 55
